// File: issue_top.f
+incdir+test
hdl/arm_issue_pkg.sv
hdl/insn_decode.sv
hdl/cond_eval.sv
hdl/flags_reg.sv
hdl/issue_stage.sv
hdl/issue_top.sv
test/tb_issue_top.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_top
FILELIST  ?= issue_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "SIMULATION PASSED"

clean:
	rm -rf $(OBJ_DIR)

// File: test/issue_model.svh
`ifndef issue_model_svh
`define issue_model_svh

// model copy of flags, in-flight slots, pending flush and the 2a outputs
logic [3:0]  mdl_flags;
logic        mdl_fdef_2a, mdl_fdef_3a, mdl_pending, mdl_bubble_2a;
logic [15:0] mdl_rdef_2a, mdl_rdef_3a;
logic [31:0] mdl_insn_2a, mdl_pc_2a;

function automatic logic [15:0] reg_mask(input logic [3:0] r);
	return (r == reg_pc) ? 16'h0 : 16'h1 << r;	// pc is never tracked
endfunction

// codes come in pairs, the odd one inverts the test
function automatic logic cond_holds(input logic [3:0] cond, input logic [3:0] f);
	logic n, z, c, v, base;
	n = f[flag_n];
	z = f[flag_z];
	c = f[flag_c];
	v = f[flag_v];
	case (cond[3:1])
	3'd0: base = z;
	3'd1: base = c;
	3'd2: base = n;
	3'd3: base = v;
	3'd4: base = c && !z;
	3'd5: base = (n == v);
	3'd6: base = !z && (n == v);
	default: base = 1'b1;	// al and nv
	endcase
	return (cond == cond_nv) ? 1'b0 : base ^ cond[0];
endfunction

// data processing, single transfer and branch, which is all the stimulus makes
function automatic void decode_ref(input logic [31:0] insn, output logic uf,
	output logic [15:0] ur, output logic df, output logic [15:0] dr);
	logic cond_used, logical, reg_op2, carry_in;
	logic [3:0] opc;
	cond_used = (insn[31:28] != cond_al);
	opc = insn[24:21];
	reg_op2 = !insn[25];
	uf = 1'b0;
	ur = 16'h0;
	df = 1'b0;
	dr = 16'h0;
	if (insn[27:26] == 2'b00)
	begin
		// shifter carry out feeds C only for logical ops with s set
		logical = insn[20] && (opc[3:2] == 2'b11 || opc[2:1] == 2'b00);
		carry_in = reg_op2 && ((logical && (insn[4] ||
			(insn[6:5] == shift_lsl && insn[11:7] == 5'd0))) ||
			(!insn[4] && insn[6:5] == shift_ror && insn[11:7] == 5'd0));	// rrx
		uf = cond_used || carry_in;
		ur = (opc == alu_mov || opc == alu_mvn) ? 16'h0 : reg_mask(insn[19:16]);
		if (reg_op2)
			ur = ur | reg_mask(insn[3:0]) | (insn[4] ? reg_mask(insn[11:8]) : 16'h0);
		df = insn[20];
		dr = (opc[3:2] == 2'b10) ? 16'h0 : reg_mask(insn[15:12]);	// compares write no reg
	end
	else if (insn[27:26] == 2'b01 && !(insn[25] && insn[4]))	// else undefined
	begin
		uf = cond_used;
		ur = reg_mask(insn[19:16]) | (insn[25] ? reg_mask(insn[3:0]) : 16'h0) |
			(insn[20] ? 16'h0 : reg_mask(insn[15:12]));
		dr = (insn[20] ? reg_mask(insn[15:12]) : 16'h0) |
			((insn[21] || !insn[24]) ? reg_mask(insn[19:16]) : 16'h0);	// base writeback
	end
	else if (insn[27:25] == 3'b101)
	begin
		uf = cond_used;
		dr = insn[24] ? reg_mask(reg_lr) : 16'h0;
	end
endfunction

task automatic model_reset();
	mdl_flags = 4'h0;
	mdl_fdef_2a = 1'b0;
	mdl_fdef_3a = 1'b0;
	mdl_rdef_2a = 16'h0;
	mdl_rdef_3a = 16'h0;
	mdl_pending = 1'b0;
	mdl_bubble_2a = 1'b1;
	mdl_insn_2a = 32'h0;
	mdl_pc_2a = 32'h0;
endtask

// one clock of the issue rules, gives the stall expected before the edge
task automatic model_cycle(input logic st, input logic fl, input logic bub,
	input logic [31:0] insn, input logic [31:0] pc, input logic fwe,
	input logic [3:0] fwd, output logic stall_out);
	logic uf, df, waiting, kill;
	logic [15:0] ur, dr;
	decode_ref(insn, uf, ur, df, dr);
	waiting = (uf && (mdl_fdef_2a || mdl_fdef_3a)) ||
		((ur & (mdl_rdef_2a | mdl_rdef_3a)) != 16'h0);
	stall_out = st || (waiting && !bub && !fl);
	kill = bub || waiting || !cond_holds(insn[31:28], mdl_flags) || fl || mdl_pending;
	if (fl && stall_out)
		mdl_pending = 1'b1;
	else if (!stall_out)
		mdl_pending = 1'b0;
	if (!st)
	begin
		mdl_fdef_3a = mdl_fdef_2a;
		mdl_fdef_2a = !kill && df;
		mdl_rdef_3a = mdl_rdef_2a;
		mdl_rdef_2a = kill ? 16'h0 : dr;
		mdl_bubble_2a = kill;
		mdl_insn_2a = insn;
		mdl_pc_2a = pc;
	end
	if (fwe)
		mdl_flags = fwd;	// seen from the next cycle on
endtask

`endif

// File: test/tb_issue_top.sv
module tb_issue_top import arm_issue_pkg::*; ();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int max_wait = 16;

	logic        clk, rst_b, stall_1a, flush_1a, bubble_1a, flags_we;
	logic [31:0] insn_1a, pc_1a;
	logic [3:0]  flags_wdata;
	logic        stall_0a, bubble_2a;
	logic [31:0] pc_2a, insn_2a;
	logic        stall_exp, held;
	logic [31:0] r;
	integer      seed;
	int          stalls;
	string       test_name;

	`include "issue_model.svh"

	issue_top DUT (.*);

	always #4 clk = ~clk;

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		if (exp !== act)
		begin
			$display("[FAIL] %s: %s expected %h actual %h", test_name, what, exp, act);
			$display("SIMULATION FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic report_timeout(input string what);
		$display("%s: %s still high after %0d cycles", test_name, what, max_wait);
		$display("SIMULATION FAILED");
		$fatal(1, "timeout");
	endtask

	// count cycles until the issue stage takes the presented slot
	task automatic wait_accept(output int cycles);
		cycles = 0;
		@(negedge clk);
		while (stall_0a)
		begin
			cycles++;
			if (cycles > max_wait)
				report_timeout("stall_0a");
			@(negedge clk);
		end
	endtask

	task automatic issue(input logic [31:0] insn, output int cycles);
		@(posedge clk);
		bubble_1a <= 1'b0;
		insn_1a <= insn;
		pc_1a <= pc_1a + 32'd4;
		wait_accept(cycles);
	endtask

	task automatic idle(input int cycles);
		repeat (cycles)
		begin
			@(posedge clk);
			bubble_1a <= 1'b1;
		end
	endtask

	task automatic write_flags(input logic [3:0] value);
		@(posedge clk);
		flags_we <= 1'b1;
		flags_wdata <= value;
		@(posedge clk);
		flags_we <= 1'b0;
	endtask

	// alu kept clear of multiply, psr and halfword space
	function automatic logic [31:0] random_insn();
		logic [31:0] x, op2;
		logic [3:0] cond, opc;
		x = $random(seed);
		op2 = $random(seed);
		cond = x[3] ? cond_al : x[7:4];
		opc = x[13:10];
		if (!x[15] && op2[4])
			op2[7] = 1'b0;
		case (x[9:8])
		2'd0, 2'd1: return {cond, 2'b00, x[15], opc, x[14] || opc[3:2] == 2'b10,
			1'b0, x[18:16], 1'b0, x[21:19], op2[11:0]};
		2'd2: return {cond, 2'b01, x[15], x[24:20], 1'b0, x[18:16], 1'b0, x[21:19], op2[11:0]};
		default: return {cond, 3'b101, x[14], op2[23:0]};
		endcase
	endfunction

	// compare against the model, then step it
	always @(negedge clk)
	begin
		if (!rst_b)
			model_reset();
		else
		begin
			check("bubble_2a", 32'(mdl_bubble_2a), 32'(bubble_2a));
			check("insn_2a", mdl_insn_2a, insn_2a);
			check("pc_2a", mdl_pc_2a, pc_2a);
			model_cycle(stall_1a, flush_1a, bubble_1a, insn_1a, pc_1a, flags_we, flags_wdata,
				stall_exp);
			check("stall_0a", 32'(stall_exp), 32'(stall_0a));
		end
	end

	initial
	begin
		clk = 1'b0;
		rst_b = 1'b0;
		stall_1a = 1'b0;
		flush_1a = 1'b0;
		bubble_1a = 1'b1;
		insn_1a = 32'h0;
		pc_1a = 32'h0;
		flags_we = 1'b0;
		flags_wdata = 4'h0;
		held = 1'b0;
		seed = 42172;
		test_name = "reset";
		repeat (4) @(posedge clk);
		rst_b <= 1'b1;

		test_name = "conditions";
		for (int fv = 0; fv < 16; fv++)
		begin
			write_flags(4'(fv));
			for (int c = 0; c < 16; c++)
			begin
				issue({4'(c), 28'h3a00000}, stalls);	// mov r0, #0
				idle(1);
				@(negedge clk);
				check("condition bubble", 32'(!cond_holds(4'(c), 4'(fv))), 32'(bubble_2a));
			end
		end

		test_name = "register hazard";
		idle(3);
		issue(32'he2813001, stalls);	// add r3, r1, #1
		issue(32'he2834001, stalls);	// add r4, r3, #1
		check("stall cycles", 32'd2, 32'(stalls));
		idle(3);
		issue(32'he2813001, stalls);
		issue(32'he3a05000, stalls);	// mov r5, #0
		issue(32'he2834001, stalls);
		check("stall cycles", 32'd1, 32'(stalls));
		idle(3);
		issue(32'he2813001, stalls);
		issue(32'he2826001, stalls);	// add r6, r2, #1
		check("stall cycles", 32'd0, 32'(stalls));

		test_name = "flag hazard";
		idle(3);
		issue(32'he2921001, stalls);	// adds r1, r2, #1
		issue(32'h03a00000, stalls);	// moveq r0, #0
		check("stall cycles", 32'd2, 32'(stalls));
		idle(3);
		issue(32'he2921001, stalls);
		issue(32'he3a00000, stalls);
		check("stall cycles", 32'd0, 32'(stalls));
		write_flags(4'b0000);	// z clear, eq fails
		idle(3);
		issue(32'h02921001, stalls);	// addseq defines nothing
		issue(32'h03a00000, stalls);
		check("stall cycles", 32'd0, 32'(stalls));

		test_name = "flush";
		idle(3);
		@(posedge clk);
		bubble_1a <= 1'b0;
		insn_1a <= 32'he3a00000;
		flush_1a <= 1'b1;
		@(posedge clk);
		flush_1a <= 1'b0;
		bubble_1a <= 1'b1;
		@(negedge clk);
		check("flushed slot", 32'd1, 32'(bubble_2a));
		idle(3);
		issue(32'he2813001, stalls);
		@(posedge clk);
		insn_1a <= 32'he2834001;	// dependent, held by downstream and flushed
		stall_1a <= 1'b1;
		flush_1a <= 1'b1;
		@(posedge clk);
		stall_1a <= 1'b0;
		flush_1a <= 1'b0;
		wait_accept(stalls);
		idle(1);
		@(negedge clk);
		check("delayed flush slot", 32'd1, 32'(bubble_2a));
		issue(32'he3a00000, stalls);
		idle(1);
		@(negedge clk);
		check("slot after flush", 32'd0, 32'(bubble_2a));

		test_name = "back-pressure";
		idle(3);
		issue(32'he3a07000, stalls);	// mov r7, #0
		@(posedge clk);
		stall_1a <= 1'b1;
		insn_1a <= 32'he3a08000;
		repeat (4)
		begin
			@(negedge clk);
			check("held insn_2a", 32'he3a07000, insn_2a);
			check("held bubble_2a", 32'd0, 32'(bubble_2a));
			check("stall_0a under hold", 32'd1, 32'(stall_0a));
		end
		@(posedge clk);
		stall_1a <= 1'b0;
		idle(2);

		test_name = "random mix";
		for (int i = 0; i < 800; i++)
		begin
			@(posedge clk);
			r = $random(seed);
			stall_1a <= (r[2:0] == 3'd0);
			flush_1a <= (r[6:3] == 4'd0);
			flags_we <= (r[9:7] == 3'd0);
			flags_wdata <= r[13:10];
			if (!held)	// decode keeps a stalled slot in place
			begin
				bubble_1a <= (r[16:14] == 3'd0);
				insn_1a <= random_insn();
				pc_1a <= pc_1a + 32'd4;
			end
			@(negedge clk);
			held = stall_0a;
		end
		@(posedge clk);
		stall_1a <= 1'b0;
		flush_1a <= 1'b0;
		flags_we <= 1'b0;
		idle(4);
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: hdl/issue_top.sv
module issue_top (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        stall_1a,
	input  logic        flush_1a,
	input  logic        bubble_1a,
	input  logic [31:0] insn_1a,
	input  logic [31:0] pc_1a,
	input  logic        flags_we,	// writeback strobe
	input  logic [3:0]  flags_wdata,
	output logic        stall_0a,
	output logic        bubble_2a,
	output logic [31:0] pc_2a,
	output logic [31:0] insn_2a
);

	logic [3:0] flags;	// current nzcv

	flags_reg u_flags (
		.clk         (clk),
		.rst_b       (rst_b),
		.flags_we    (flags_we),
		.flags_wdata (flags_wdata),
		.flags       (flags)
	);

	issue_stage u_issue (
		.clk       (clk),
		.rst_b     (rst_b),
		.stall_1a  (stall_1a),
		.flush_1a  (flush_1a),
		.bubble_1a (bubble_1a),
		.insn_1a   (insn_1a),
		.pc_1a     (pc_1a),
		.flags     (flags),
		.stall_0a  (stall_0a),
		.bubble_2a (bubble_2a),
		.pc_2a     (pc_2a),
		.insn_2a   (insn_2a)
	);

endmodule

// File: hdl/issue_stage.sv
module issue_stage import arm_issue_pkg::*; (
	input  logic        clk,
	input  logic        rst_b,
	input  logic        stall_1a,	// pipeline control
	input  logic        flush_1a,
	input  logic        bubble_1a,	// from decode
	input  logic [31:0] insn_1a,
	input  logic [31:0] pc_1a,
	input  logic [3:0]  flags,
	output logic        stall_0a,	// back to decode
	output logic        bubble_2a,	// toward execute
	output logic [31:0] pc_2a,
	output logic [31:0] insn_2a
);

	logic                use_flags_1a;
	logic [num_regs-1:0] use_regs_1a;
	logic                def_flags_1a;
	logic [num_regs-1:0] def_regs_1a;
	logic                condition_met_1a;

	insn_decode u_decode (
		.insn      (insn_1a),
		.use_flags (use_flags_1a),
		.use_regs  (use_regs_1a),
		.def_flags (def_flags_1a),
		.def_regs  (def_regs_1a)
	);

	cond_eval u_cond (
		.cond          (insn_1a[31:28]),
		.flags         (flags),
		.condition_met (condition_met_1a)
	);

	// defs still ahead of writeback, one slot per stage
	logic                flags_inflight_2a, flags_inflight_3a;
	logic [num_regs-1:0] regs_inflight_2a, regs_inflight_3a;
	logic                waiting_flags_1a, waiting_regs_1a, waiting_1a;
	logic                delayed_flush_1a;
	logic                kill_1a;

	assign waiting_flags_1a = use_flags_1a && (flags_inflight_2a || flags_inflight_3a);
	assign waiting_regs_1a = |(use_regs_1a & (regs_inflight_2a | regs_inflight_3a));
	assign waiting_1a = waiting_flags_1a || waiting_regs_1a;
	assign stall_0a = stall_1a || (waiting_1a && !bubble_1a && !flush_1a);

	// anything that turns this slot into a bubble
	assign kill_1a = bubble_1a || waiting_1a || !condition_met_1a ||
		flush_1a || delayed_flush_1a;

	// flush seen while held, applied to the next slot that moves
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			delayed_flush_1a <= 1'b0;
		else if (flush_1a && stall_0a)
			delayed_flush_1a <= 1'b1;
		else if (!stall_0a)
			delayed_flush_1a <= 1'b0;
	end

	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
		begin
			flags_inflight_2a <= 1'b0;
			flags_inflight_3a <= 1'b0;
			regs_inflight_2a <= '0;
			regs_inflight_3a <= '0;
			bubble_2a <= 1'b1;
			pc_2a <= '0;
			insn_2a <= '0;
		end
		else if (!stall_1a)
		begin
			flags_inflight_3a <= flags_inflight_2a;
			flags_inflight_2a <= kill_1a ? 1'b0 : def_flags_1a;
			regs_inflight_3a <= regs_inflight_2a;
			regs_inflight_2a <= kill_1a ? '0 : def_regs_1a;
			bubble_2a <= kill_1a;
			pc_2a <= pc_1a;
			insn_2a <= insn_1a;
		end
	end

	a_reset_bubble: assert property (@(posedge clk) $rose(rst_b) |-> bubble_2a);

	// downstream hold freezes the execute-bound slot
	a_hold_insn: assert property (
		@(posedge clk) disable iff (!rst_b)
		stall_1a |=> $stable(insn_2a)
	);

	a_no_pc_tracked: assert property (
		@(posedge clk) disable iff (!rst_b)
		!regs_inflight_2a[reg_pc] && !regs_inflight_3a[reg_pc]
	);

endmodule

// File: hdl/flags_reg.sv
module flags_reg import arm_issue_pkg::*; (
	input  logic       clk,
	input  logic       rst_b,
	input  logic       flags_we,
	input  logic [3:0] flags_wdata,
	output logic [3:0] flags
);

	// nzcv as written back and read by the issue logic next cycle
	always_ff @(posedge clk or negedge rst_b)
	begin
		if (!rst_b)
			flags <= 4'b0000;
		else if (flags_we)
			flags <= flags_wdata;
	end

	// writeback must not hand over a half-computed result
	a_wdata_known: assert property (
		@(posedge clk) disable iff (!rst_b)
		flags_we |-> !$isunknown(flags_wdata)
	) else $error("flags_wdata unknown on write");

endmodule

// File: hdl/cond_eval.sv
module cond_eval import arm_issue_pkg::*; (
	input  logic [3:0] cond,
	input  logic [3:0] flags,
	output logic       condition_met
);

	logic n, z, c, v;

	assign n = flags[flag_n];
	assign z = flags[flag_z];
	assign c = flags[flag_c];
	assign v = flags[flag_v];

	always_comb
	begin
		case (cond)
		cond_eq: condition_met = z;
		cond_ne: condition_met = !z;
		cond_cs: condition_met = c;
		cond_cc: condition_met = !c;
		cond_mi: condition_met = n;
		cond_pl: condition_met = !n;
		cond_vs: condition_met = v;
		cond_vc: condition_met = !v;
		cond_hi: condition_met = c && !z;	// unsigned higher
		cond_ls: condition_met = !c || z;
		cond_ge: condition_met = (n == v);	// signed compares
		cond_lt: condition_met = (n != v);
		cond_gt: condition_met = !z && (n == v);
		cond_le: condition_met = z || (n != v);
		cond_al: condition_met = 1'b1;
		cond_nv: condition_met = 1'b0;	// never
		default: condition_met = 1'b0;
		endcase
	end

endmodule

// File: hdl/insn_decode.sv
module insn_decode import arm_issue_pkg::*; (
	input  logic [31:0]         insn,
	output logic                use_flags,
	output logic [num_regs-1:0] use_regs,
	output logic                def_flags,
	output logic [num_regs-1:0] def_regs
);

	logic [3:0] rn, rd, rs, rm;
	logic [3:0] rd_mul, rn_mul;
	logic [3:0] alu_opc;
	logic       cond_matters;
	logic [num_regs-1:0] reg_list;

	assign rn = insn[19:16];
	assign rd = insn[15:12];
	assign rs = insn[11:8];
	assign rm = insn[3:0];
	assign rd_mul = insn[19:16];	// multiply swaps rn and rd
	assign rn_mul = insn[15:12];
	assign alu_opc = insn[24:21];
	assign cond_matters = (insn[31:28] != cond_al);
	assign reg_list = insn[15:0] & ~(num_regs'(1) << reg_pc);	// block transfer list, pc dropped

	function automatic logic [num_regs-1:0] reg_bit(input logic [3:0] r);
		if (r == reg_pc)
			return '0;
		return num_regs'(1) << r;
	endfunction

	// ops whose carry out comes from the shifter
	function automatic logic alu_is_logical(input logic [3:0] op);
		case (op)
		alu_and, alu_eor, alu_tst, alu_teq, alu_orr, alu_mov, alu_bic, alu_mvn:
			return 1'b1;
		alu_sub, alu_rsb, alu_add, alu_adc, alu_sbc, alu_rsc, alu_cmp, alu_cmn:
			return 1'b0;
		default:
			return 1'b0;
		endcase
	endfunction

	function automatic logic alu_flags_only(input logic [3:0] op);
		return (op == alu_tst) || (op == alu_teq) || (op == alu_cmp) || (op == alu_cmn);
	endfunction

	// register operand shift that reads C, op2 is insn[11:0]
	function automatic logic shift_needs_carry(input logic [11:0] op2, input logic logical_s);
		logic by_reg;
		logic [4:0] amount;
		by_reg = op2[4];
		amount = op2[11:7];
		case (op2[6:5])
		shift_lsl: return logical_s && (by_reg || amount == 5'd0);	// zero shift passes C
		shift_lsr, shift_asr: return logical_s && by_reg;
		shift_ror: return by_reg ? logical_s : (amount == 5'd0);	// rrx
		default: return 1'b0;
		endcase
	endfunction

	always_comb
	begin
		use_flags = 1'b0;
		use_regs = '0;
		def_flags = 1'b0;
		def_regs = '0;
		casez (insn)
		pat_mult:	// ahead of alu, it is a subset of it
		begin
			use_flags = cond_matters;
			use_regs = (insn[21] ? reg_bit(rn_mul) : '0) | reg_bit(rs) | reg_bit(rm);	// accumulate
			def_flags = insn[20];
			def_regs = reg_bit(rd_mul);
		end
		pat_mrs:
		begin
			use_flags = cond_matters || !insn[22];	// source is cpsr
			def_regs = reg_bit(rd);
		end
		pat_msr:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rm);
			def_flags = 1'b1;
		end
		pat_msr_flags:
		begin
			use_flags = cond_matters;
			use_regs = insn[25] ? '0 : reg_bit(rm);
			def_flags = 1'b1;
		end
		pat_swp:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rn) | reg_bit(rm);
			def_regs = reg_bit(rd);
		end
		pat_bx:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rm);
			def_regs = insn[5] ? reg_bit(reg_lr) : '0;	// blx links
		end
		pat_hdata_reg:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rn) | reg_bit(rm) | (insn[20] ? '0 : reg_bit(rd));
			def_regs = insn[20] ? reg_bit(rd) : '0;
		end
		pat_hdata_imm:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rn) | (insn[20] ? '0 : reg_bit(rd));
			def_regs = insn[20] ? reg_bit(rd) : '0;
		end
		pat_alu:
		begin
			use_flags = cond_matters || (!insn[25] &&
				shift_needs_carry(insn[11:0], insn[20] && alu_is_logical(alu_opc)));
			use_regs = (insn[25] ? '0 : (insn[4] ? (reg_bit(rs) | reg_bit(rm)) : reg_bit(rm))) |
				((alu_opc != alu_mov && alu_opc != alu_mvn) ? reg_bit(rn) : '0);
			def_flags = insn[20];
			def_regs = alu_flags_only(alu_opc) ? '0 : reg_bit(rd);
		end
		pat_ldrstr_undef:
		begin
			// undefined space, touches nothing
			use_flags = 1'b0;
			use_regs = '0;
		end
		pat_ldrstr:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rn) | (insn[25] ? reg_bit(rm) : '0) | (insn[20] ? '0 : reg_bit(rd));
			def_regs = (insn[20] ? reg_bit(rd) : '0) |
				((insn[21] || !insn[24]) ? reg_bit(rn) : '0);	// writeback or post-index
		end
		pat_ldmstm:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rn) | (insn[20] ? '0 : reg_list);
			def_flags = insn[22];	// covers ldm with psr restore
			def_regs = (insn[21] ? reg_bit(rn) : '0) | (insn[20] ? reg_list : '0);
		end
		pat_branch:
		begin
			use_flags = cond_matters;
			def_regs = insn[24] ? reg_bit(reg_lr) : '0;
		end
		pat_ldcstc:
		begin
			use_flags = cond_matters;
			use_regs = reg_bit(rn);
			def_regs = insn[21] ? reg_bit(rn) : '0;
		end
		pat_cdp: use_flags = cond_matters;
		pat_mrcmcr:
		begin
			use_flags = cond_matters;
			use_regs = insn[20] ? '0 : reg_bit(rd);	// mcr reads rd
			def_regs = insn[20] ? reg_bit(rd) : '0;
		end
		pat_swi: use_flags = cond_matters;
		default: use_flags = 1'b0;	// no class, nothing read or written
		endcase
	end

endmodule

// File: hdl/arm_issue_pkg.sv
package arm_issue_pkg;

	// condition field, insn[31:28]
	localparam logic [3:0] cond_eq = 4'h0;
	localparam logic [3:0] cond_ne = 4'h1;
	localparam logic [3:0] cond_cs = 4'h2;
	localparam logic [3:0] cond_cc = 4'h3;
	localparam logic [3:0] cond_mi = 4'h4;
	localparam logic [3:0] cond_pl = 4'h5;
	localparam logic [3:0] cond_vs = 4'h6;
	localparam logic [3:0] cond_vc = 4'h7;
	localparam logic [3:0] cond_hi = 4'h8;
	localparam logic [3:0] cond_ls = 4'h9;
	localparam logic [3:0] cond_ge = 4'ha;
	localparam logic [3:0] cond_lt = 4'hb;
	localparam logic [3:0] cond_gt = 4'hc;
	localparam logic [3:0] cond_le = 4'hd;
	localparam logic [3:0] cond_al = 4'he;
	localparam logic [3:0] cond_nv = 4'hf;

	// data processing opcode, insn[24:21]
	localparam logic [3:0] alu_and = 4'h0;
	localparam logic [3:0] alu_eor = 4'h1;
	localparam logic [3:0] alu_sub = 4'h2;
	localparam logic [3:0] alu_rsb = 4'h3;
	localparam logic [3:0] alu_add = 4'h4;
	localparam logic [3:0] alu_adc = 4'h5;
	localparam logic [3:0] alu_sbc = 4'h6;
	localparam logic [3:0] alu_rsc = 4'h7;
	localparam logic [3:0] alu_tst = 4'h8;
	localparam logic [3:0] alu_teq = 4'h9;
	localparam logic [3:0] alu_cmp = 4'ha;
	localparam logic [3:0] alu_cmn = 4'hb;
	localparam logic [3:0] alu_orr = 4'hc;
	localparam logic [3:0] alu_mov = 4'hd;
	localparam logic [3:0] alu_bic = 4'he;
	localparam logic [3:0] alu_mvn = 4'hf;

	// shift kind, insn[6:5]
	localparam logic [1:0] shift_lsl = 2'b00;
	localparam logic [1:0] shift_lsr = 2'b01;
	localparam logic [1:0] shift_asr = 2'b10;
	localparam logic [1:0] shift_ror = 2'b11;

	// flags word is {n, z, c, v}
	localparam int flag_n = 3;
	localparam int flag_z = 2;
	localparam int flag_c = 1;
	localparam int flag_v = 0;

	localparam int num_regs = 16;
	localparam logic [3:0] reg_pc = 4'd15;	// never tracked
	localparam logic [3:0] reg_lr = 4'd14;

	// class patterns, ? is don't care; tried top to bottom
	localparam logic [31:0] pat_mult         = 32'b????_0000_00??_????_????_????_1001_????;
	localparam logic [31:0] pat_mrs          = 32'b????_0001_0?00_1111_????_0000_0000_0000;
	localparam logic [31:0] pat_msr          = 32'b????_0001_0?10_1001_1111_0000_0000_????;
	localparam logic [31:0] pat_msr_flags    = 32'b????_00?1_0?10_1000_1111_????_????_????;
	localparam logic [31:0] pat_swp          = 32'b????_0001_0?00_????_????_0000_1001_????;
	localparam logic [31:0] pat_bx           = 32'b????_0001_0010_1111_1111_1111_00?1_????;
	localparam logic [31:0] pat_hdata_reg    = 32'b????_000?_?0??_????_????_0000_1??1_????;
	localparam logic [31:0] pat_hdata_imm    = 32'b????_000?_?1??_????_????_????_1??1_????;
	localparam logic [31:0] pat_alu          = 32'b????_00??_????_????_????_????_????_????;
	localparam logic [31:0] pat_ldrstr_undef = 32'b????_011?_????_????_????_????_???1_????;
	localparam logic [31:0] pat_ldrstr       = 32'b????_01??_????_????_????_????_????_????;
	localparam logic [31:0] pat_ldmstm       = 32'b????_100?_????_????_????_????_????_????;
	localparam logic [31:0] pat_branch       = 32'b????_101?_????_????_????_????_????_????;
	localparam logic [31:0] pat_ldcstc       = 32'b????_110?_????_????_????_????_????_????;
	localparam logic [31:0] pat_cdp          = 32'b????_1110_????_????_????_????_???0_????;
	localparam logic [31:0] pat_mrcmcr       = 32'b????_1110_????_????_????_????_???1_????;
	localparam logic [31:0] pat_swi          = 32'b????_1111_????_????_????_????_????_????;

endpackage
